// ==== hw/lc3b_isa_pkg.sv ====
package lc3b_isa_pkg;

	localparam int WORD_W = 16;

	typedef logic [WORD_W-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	typedef struct packed
	{
		logic n;
		logic z;
		logic p;
	} lc3b_nzp;

	typedef enum logic [3:0]
	{
		BR  = 4'b0000,
		ADD = 4'b0001,
		AND = 4'b0101,
		LDR = 4'b0110,
		STR = 4'b0111,
		NOT = 4'b1001,
		LEA = 4'b1110
	} lc3b_opcode;

	// Reads as BR with no condition bits, never taken
	localparam lc3b_word NOP_WORD = '0;
	localparam lc3b_word RESET_PC = '0;
	localparam lc3b_nzp RESET_NZP = 3'b010;

	// Register form, sr2 sits in imm5[2:0] when imm_flag is low
	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_reg dr_nzp;
		lc3b_reg sr1_base;
		logic imm_flag;
		logic [4:0] imm5;
	} lc3b_reg_fmt;

	// Offset form, base and offset6 share the offset9 bits
	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_reg dr_nzp;
		logic [8:0] offset9;
	} lc3b_ofs_fmt;

	typedef union packed
	{
		lc3b_reg_fmt regs;
		lc3b_ofs_fmt offs;
	} lc3b_instr;

	function automatic lc3b_nzp gen_nzp(input lc3b_word value);
		lc3b_nzp nzp;
		nzp.n = value[WORD_W-1];
		nzp.z = (value == '0);
		nzp.p = !value[WORD_W-1] && (value != '0);
		return nzp;
	endfunction

endpackage

// ==== hw/lc3b_pipe_pkg.sv ====
package lc3b_pipe_pkg;

	typedef enum logic [1:0]
	{
		ADD,
		AND,
		NOT,
		PASS_B
	} lc3b_alu_op;

	typedef struct packed
	{
		lc3b_alu_op alu_op;
		logic sr2_imm;
		logic addr_base_pc;
		logic offset9_sel;
		logic load_reg;
		logic load_cc;
		logic mem_read;
		logic mem_write;
		logic br_op;
		logic wb_from_mem;
		logic uses_sr1;
		logic uses_sr2;
	} lc3b_ctrl;

	typedef enum logic [1:0]
	{
		REG,
		EX_MEM,
		MEM_WB
	} lc3b_fwd_sel;

	typedef struct packed
	{
		logic valid;
		lc3b_isa_pkg::lc3b_word pc_next;
		lc3b_isa_pkg::lc3b_instr instr;
	} lc3b_if_id;

	typedef struct packed
	{
		logic valid;
		lc3b_isa_pkg::lc3b_word pc_next;
		lc3b_isa_pkg::lc3b_instr instr;
		lc3b_ctrl ctrl;
		lc3b_isa_pkg::lc3b_word sr1_val;
		lc3b_isa_pkg::lc3b_word sr2_val;
		lc3b_isa_pkg::lc3b_reg src1;
		lc3b_isa_pkg::lc3b_reg src2;
		lc3b_isa_pkg::lc3b_reg dest;
	} lc3b_id_ex;

	typedef struct packed
	{
		logic valid;
		lc3b_ctrl ctrl;
		lc3b_isa_pkg::lc3b_word result;
		lc3b_isa_pkg::lc3b_word addr;
		lc3b_isa_pkg::lc3b_word wdata;
		lc3b_isa_pkg::lc3b_reg dest;
		lc3b_isa_pkg::lc3b_nzp br_nzp;
	} lc3b_ex_mem;

	typedef struct packed
	{
		logic valid;
		lc3b_ctrl ctrl;
		lc3b_isa_pkg::lc3b_word result;
		lc3b_isa_pkg::lc3b_reg dest;
	} lc3b_mem_wb;

	typedef struct packed
	{
		logic read;
		logic write;
		lc3b_isa_pkg::lc3b_word addr;
		lc3b_isa_pkg::lc3b_word wdata;
	} lc3b_dmem_req;

	typedef struct packed
	{
		logic load_reg;
		logic load_cc;
		lc3b_isa_pkg::lc3b_reg dest;
		lc3b_isa_pkg::lc3b_word value;
	} lc3b_wb;

endpackage

// ==== hw/lc3b_fetch.sv ====
module lc3b_fetch
(
	input logic clk,
	input logic i_arst_n,
	input lc3b_isa_pkg::lc3b_word i_imem_rdata,
	input logic i_br_taken,
	input lc3b_isa_pkg::lc3b_word i_br_target,
	output lc3b_isa_pkg::lc3b_word o_imem_addr,
	output lc3b_pipe_pkg::lc3b_if_id o_if_id
);

	lc3b_isa_pkg::lc3b_word pc;
	lc3b_isa_pkg::lc3b_word pc_plus2;

	assign pc_plus2 = pc + lc3b_isa_pkg::WORD_W'(2);
	assign o_imem_addr = pc;

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			pc <= lc3b_isa_pkg::RESET_PC;
		else if (i_br_taken)
			pc <= i_br_target;
		else
			pc <= pc_plus2;
	end

	// Word fetched under a taken branch is squashed to a NOP
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_if_id.valid <= 1'b0;
			o_if_id.pc_next <= lc3b_isa_pkg::RESET_PC;
			o_if_id.instr <= lc3b_isa_pkg::NOP_WORD;
		end
		else
		begin
			o_if_id.valid <= !i_br_taken;
			o_if_id.pc_next <= pc_plus2;
			o_if_id.instr <= i_br_taken ? lc3b_isa_pkg::NOP_WORD : i_imem_rdata;
		end
	end

endmodule

// ==== hw/lc3b_control_decode.sv ====
module lc3b_control_decode
(
	input lc3b_isa_pkg::lc3b_instr i_instr,
	output lc3b_pipe_pkg::lc3b_ctrl o_ctrl
);

	always_comb
	begin
		o_ctrl = '0;
		case (i_instr.regs.opcode)
			lc3b_isa_pkg::ADD, lc3b_isa_pkg::AND:
			begin
				if (i_instr.regs.opcode == lc3b_isa_pkg::ADD)
					o_ctrl.alu_op = lc3b_pipe_pkg::ADD;
				else
					o_ctrl.alu_op = lc3b_pipe_pkg::AND;
				o_ctrl.sr2_imm = i_instr.regs.imm_flag;
				o_ctrl.load_reg = 1'b1;
				o_ctrl.load_cc = 1'b1;
				o_ctrl.uses_sr1 = 1'b1;
				o_ctrl.uses_sr2 = !i_instr.regs.imm_flag;
			end
			lc3b_isa_pkg::NOT:
			begin
				o_ctrl.alu_op = lc3b_pipe_pkg::NOT;
				o_ctrl.load_reg = 1'b1;
				o_ctrl.load_cc = 1'b1;
				o_ctrl.uses_sr1 = 1'b1;
			end
			// LC-3b LEA leaves cc alone
			lc3b_isa_pkg::LEA:
			begin
				o_ctrl.alu_op = lc3b_pipe_pkg::PASS_B;
				o_ctrl.addr_base_pc = 1'b1;
				o_ctrl.offset9_sel = 1'b1;
				o_ctrl.load_reg = 1'b1;
			end
			lc3b_isa_pkg::LDR:
			begin
				o_ctrl.mem_read = 1'b1;
				o_ctrl.wb_from_mem = 1'b1;
				o_ctrl.load_reg = 1'b1;
				o_ctrl.load_cc = 1'b1;
				o_ctrl.uses_sr1 = 1'b1;
			end
			lc3b_isa_pkg::STR:
			begin
				o_ctrl.mem_write = 1'b1;
				o_ctrl.uses_sr1 = 1'b1;
				o_ctrl.uses_sr2 = 1'b1;
			end
			lc3b_isa_pkg::BR:
			begin
				o_ctrl.br_op = 1'b1;
				o_ctrl.addr_base_pc = 1'b1;
				o_ctrl.offset9_sel = 1'b1;
			end
			default:
				o_ctrl = '0;
		endcase
	end

endmodule

// ==== hw/lc3b_decode.sv ====
module lc3b_decode
(
	input logic clk,
	input logic i_arst_n,
	input lc3b_pipe_pkg::lc3b_if_id i_if_id,
	input logic i_flush,
	input lc3b_pipe_pkg::lc3b_wb i_wb,
	output lc3b_pipe_pkg::lc3b_id_ex o_id_ex,
	output lc3b_isa_pkg::lc3b_nzp o_cc
);

	lc3b_pipe_pkg::lc3b_ctrl ctrl;
	lc3b_isa_pkg::lc3b_word rf [8];
	lc3b_isa_pkg::lc3b_nzp cc;
	lc3b_isa_pkg::lc3b_reg src1;
	lc3b_isa_pkg::lc3b_reg src2;
	lc3b_isa_pkg::lc3b_word sr1_val;
	lc3b_isa_pkg::lc3b_word sr2_val;

	lc3b_control_decode u_control_decode
	(
		.i_instr(i_if_id.instr),
		.o_ctrl(ctrl)
	);

	// STR reads its data register on the second port
	assign src1 = i_if_id.instr.regs.sr1_base;
	assign src2 = ctrl.mem_write ? i_if_id.instr.regs.dr_nzp : i_if_id.instr.regs.imm5[2:0];

	// Write-through from the writeback bus
	assign sr1_val = (i_wb.load_reg && i_wb.dest == src1) ? i_wb.value : rf[src1];
	assign sr2_val = (i_wb.load_reg && i_wb.dest == src2) ? i_wb.value : rf[src2];
	assign o_cc = cc;

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < 8; i++)
				rf[i] <= '0;
		end
		else if (i_wb.load_reg)
			rf[i_wb.dest] <= i_wb.value;
	end

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			cc <= lc3b_isa_pkg::RESET_NZP;
		else if (i_wb.load_cc)
			cc <= lc3b_isa_pkg::gen_nzp(i_wb.value);
	end

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_id_ex <= '0;
		else
		begin
			o_id_ex.valid <= i_if_id.valid && !i_flush;
			o_id_ex.pc_next <= i_if_id.pc_next;
			o_id_ex.instr <= i_if_id.instr;
			o_id_ex.ctrl <= ctrl;
			o_id_ex.sr1_val <= sr1_val;
			o_id_ex.sr2_val <= sr2_val;
			o_id_ex.src1 <= src1;
			o_id_ex.src2 <= src2;
			o_id_ex.dest <= i_if_id.instr.regs.dr_nzp;
		end
	end

endmodule

// ==== hw/lc3b_execute.sv ====
module lc3b_execute
(
	input logic clk,
	input logic i_arst_n,
	input lc3b_pipe_pkg::lc3b_id_ex i_id_ex,
	input lc3b_pipe_pkg::lc3b_wb i_ex_mem_fwd,
	input lc3b_pipe_pkg::lc3b_wb i_mem_wb_fwd,
	input logic i_flush,
	output lc3b_pipe_pkg::lc3b_ex_mem o_ex_mem
);

	lc3b_pipe_pkg::lc3b_fwd_sel sel1;
	lc3b_pipe_pkg::lc3b_fwd_sel sel2;
	lc3b_isa_pkg::lc3b_word op1;
	lc3b_isa_pkg::lc3b_word op2;
	lc3b_isa_pkg::lc3b_word sext5;
	lc3b_isa_pkg::lc3b_word sext6;
	lc3b_isa_pkg::lc3b_word sext9;
	lc3b_isa_pkg::lc3b_word alu_b;
	lc3b_isa_pkg::lc3b_word alu_out;
	lc3b_isa_pkg::lc3b_word addr;

	// Younger producer first
	function automatic lc3b_pipe_pkg::lc3b_fwd_sel fwd_pick
	(
		input lc3b_isa_pkg::lc3b_reg src,
		input logic used,
		input lc3b_pipe_pkg::lc3b_wb ex_mem,
		input lc3b_pipe_pkg::lc3b_wb mem_wb
	);
		if (used && ex_mem.load_reg && ex_mem.dest == src)
			return lc3b_pipe_pkg::EX_MEM;
		else if (used && mem_wb.load_reg && mem_wb.dest == src)
			return lc3b_pipe_pkg::MEM_WB;
		else
			return lc3b_pipe_pkg::REG;
	endfunction

	function automatic lc3b_isa_pkg::lc3b_word fwd_mux
	(
		input lc3b_pipe_pkg::lc3b_fwd_sel sel,
		input lc3b_isa_pkg::lc3b_word reg_val,
		input lc3b_isa_pkg::lc3b_word ex_mem_val,
		input lc3b_isa_pkg::lc3b_word mem_wb_val
	);
		case (sel)
			lc3b_pipe_pkg::EX_MEM: return ex_mem_val;
			lc3b_pipe_pkg::MEM_WB: return mem_wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign sel1 = fwd_pick(i_id_ex.src1, i_id_ex.ctrl.uses_sr1, i_ex_mem_fwd, i_mem_wb_fwd);
	assign sel2 = fwd_pick(i_id_ex.src2, i_id_ex.ctrl.uses_sr2, i_ex_mem_fwd, i_mem_wb_fwd);
	assign op1 = fwd_mux(sel1, i_id_ex.sr1_val, i_ex_mem_fwd.value, i_mem_wb_fwd.value);
	assign op2 = fwd_mux(sel2, i_id_ex.sr2_val, i_ex_mem_fwd.value, i_mem_wb_fwd.value);

	assign sext5 = lc3b_isa_pkg::WORD_W'(signed'(i_id_ex.instr.regs.imm5));
	assign sext6 = lc3b_isa_pkg::WORD_W'(signed'(i_id_ex.instr.offs.offset9[5:0]));
	assign sext9 = lc3b_isa_pkg::WORD_W'(signed'(i_id_ex.instr.offs.offset9));

	// Base register or PC+2, plus word offset
	always_comb
	begin
		addr = i_id_ex.ctrl.addr_base_pc ? i_id_ex.pc_next : op1;
		addr = addr + ((i_id_ex.ctrl.offset9_sel ? sext9 : sext6) << 1);
	end

	assign alu_b = i_id_ex.ctrl.sr2_imm ? sext5 : op2;

	always_comb
	begin
		case (i_id_ex.ctrl.alu_op)
			lc3b_pipe_pkg::ADD: alu_out = op1 + alu_b;
			lc3b_pipe_pkg::AND: alu_out = op1 & alu_b;
			lc3b_pipe_pkg::NOT: alu_out = ~op1;
			// LEA, the address adder drives the B side
			default: alu_out = addr;
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_ex_mem <= '0;
		else
		begin
			o_ex_mem.valid <= i_id_ex.valid && !i_flush;
			o_ex_mem.ctrl <= i_id_ex.ctrl;
			o_ex_mem.result <= alu_out;
			o_ex_mem.addr <= addr;
			o_ex_mem.wdata <= op2;
			o_ex_mem.dest <= i_id_ex.dest;
			o_ex_mem.br_nzp <= i_id_ex.instr.offs.dr_nzp;
		end
	end

endmodule

// ==== hw/lc3b_memory.sv ====
module lc3b_memory
(
	input logic clk,
	input logic i_arst_n,
	input lc3b_pipe_pkg::lc3b_ex_mem i_ex_mem,
	input lc3b_isa_pkg::lc3b_word i_dmem_rdata,
	input lc3b_isa_pkg::lc3b_nzp i_cc,
	output lc3b_pipe_pkg::lc3b_dmem_req o_dmem,
	output lc3b_pipe_pkg::lc3b_wb o_ex_mem_fwd,
	output lc3b_pipe_pkg::lc3b_wb o_mem_wb,
	output logic o_br_taken,
	output lc3b_isa_pkg::lc3b_word o_br_target
);

	lc3b_pipe_pkg::lc3b_mem_wb mem_wb;
	lc3b_isa_pkg::lc3b_word mem_result;
	lc3b_isa_pkg::lc3b_nzp flush_nzp;

	always_comb
	begin
		o_dmem.read = i_ex_mem.valid && i_ex_mem.ctrl.mem_read;
		o_dmem.write = i_ex_mem.valid && i_ex_mem.ctrl.mem_write;
		o_dmem.addr = i_ex_mem.addr;
		o_dmem.wdata = i_ex_mem.wdata;
	end

	assign mem_result = i_ex_mem.ctrl.wb_from_mem ? i_dmem_rdata : i_ex_mem.result;

	always_comb
	begin
		o_ex_mem_fwd.load_reg = i_ex_mem.valid && i_ex_mem.ctrl.load_reg;
		o_ex_mem_fwd.load_cc = i_ex_mem.valid && i_ex_mem.ctrl.load_cc;
		o_ex_mem_fwd.dest = i_ex_mem.dest;
		o_ex_mem_fwd.value = mem_result;
	end

	// cc from writeback is not in the register until the next edge
	assign flush_nzp = o_mem_wb.load_cc ? lc3b_isa_pkg::gen_nzp(o_mem_wb.value) : i_cc;
	assign o_br_taken = i_ex_mem.valid && i_ex_mem.ctrl.br_op && |(i_ex_mem.br_nzp & flush_nzp);
	assign o_br_target = i_ex_mem.addr;

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			mem_wb <= '0;
		else
		begin
			mem_wb.valid <= i_ex_mem.valid;
			mem_wb.ctrl <= i_ex_mem.ctrl;
			mem_wb.result <= mem_result;
			mem_wb.dest <= i_ex_mem.dest;
		end
	end

	always_comb
	begin
		o_mem_wb.load_reg = mem_wb.valid && mem_wb.ctrl.load_reg;
		o_mem_wb.load_cc = mem_wb.valid && mem_wb.ctrl.load_cc;
		o_mem_wb.dest = mem_wb.dest;
		o_mem_wb.value = mem_wb.result;
	end

endmodule

// ==== hw/lc3b_core.sv ====
module lc3b_core
(
	input logic clk,
	input logic i_arst_n,
	input lc3b_isa_pkg::lc3b_word i_imem_rdata,
	input lc3b_isa_pkg::lc3b_word i_dmem_rdata,
	output lc3b_isa_pkg::lc3b_word o_imem_addr,
	output lc3b_pipe_pkg::lc3b_dmem_req o_dmem
);

	lc3b_pipe_pkg::lc3b_if_id if_id;
	lc3b_pipe_pkg::lc3b_id_ex id_ex;
	lc3b_pipe_pkg::lc3b_ex_mem ex_mem;
	lc3b_pipe_pkg::lc3b_wb ex_mem_fwd;
	lc3b_pipe_pkg::lc3b_wb mem_wb;
	lc3b_isa_pkg::lc3b_nzp cc;
	lc3b_isa_pkg::lc3b_word br_target;
	logic br_taken;

	lc3b_fetch u_fetch
	(
		.clk,
		.i_arst_n,
		.i_imem_rdata,
		.i_br_taken(br_taken),
		.i_br_target(br_target),
		.o_imem_addr,
		.o_if_id(if_id)
	);

	lc3b_decode u_decode
	(
		.clk,
		.i_arst_n,
		.i_if_id(if_id),
		.i_flush(br_taken),
		.i_wb(mem_wb),
		.o_id_ex(id_ex),
		.o_cc(cc)
	);

	lc3b_execute u_execute
	(
		.clk,
		.i_arst_n,
		.i_id_ex(id_ex),
		.i_ex_mem_fwd(ex_mem_fwd),
		.i_mem_wb_fwd(mem_wb),
		.i_flush(br_taken),
		.o_ex_mem(ex_mem)
	);

	// Branch resolves here and squashes the three younger slots
	lc3b_memory u_memory
	(
		.clk,
		.i_arst_n,
		.i_ex_mem(ex_mem),
		.i_dmem_rdata,
		.i_cc(cc),
		.o_dmem,
		.o_ex_mem_fwd(ex_mem_fwd),
		.o_mem_wb(mem_wb),
		.o_br_taken(br_taken),
		.o_br_target(br_target)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen
(
	output logic o_clk,
	output logic o_arst_n
);

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 16;

	initial
	begin
		o_clk = 1'b0;
		forever
			#(PERIOD / 2) o_clk = ~o_clk;
	end

	// Released on a falling edge, away from the rising edge
	initial
	begin
		o_arst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(negedge o_clk);
		o_arst_n = 1'b1;
	end

endmodule

// ==== tb/lc3b_core_tb.sv ====
module lc3b_core_tb;

	localparam int ROM_WORDS = 64;
	localparam int RAM_WORDS = 256;
	localparam int MAX_STORES = 16;

	logic clk;
	logic arst_n;
	lc3b_isa_pkg::lc3b_word imem_addr;
	lc3b_isa_pkg::lc3b_word imem_rdata = '0;
	lc3b_isa_pkg::lc3b_word dmem_rdata = '0;
	lc3b_pipe_pkg::lc3b_dmem_req dmem;

	lc3b_isa_pkg::lc3b_word rom [ROM_WORDS];
	lc3b_isa_pkg::lc3b_word ram [RAM_WORDS];
	// Register values as the program leaves them
	lc3b_isa_pkg::lc3b_word regs [8];
	lc3b_isa_pkg::lc3b_word exp_addr [MAX_STORES];
	lc3b_isa_pkg::lc3b_word exp_data [MAX_STORES];
	lc3b_isa_pkg::lc3b_word halt_pc;
	int prog_len;
	int num_stores;
	int cycle_limit;
	int cycles = 0;

	tb_clock_gen u_clock_gen
	(
		.o_clk(clk),
		.o_arst_n(arst_n)
	);

	lc3b_core DUT
	(
		.clk(clk),
		.i_arst_n(arst_n),
		.i_imem_rdata(imem_rdata),
		.i_dmem_rdata(dmem_rdata),
		.o_imem_addr(imem_addr),
		.o_dmem(dmem)
	);

	task automatic check_value
	(
		input lc3b_isa_pkg::lc3b_word actual,
		input lc3b_isa_pkg::lc3b_word expected,
		input string what
	);
		if (actual !== expected)
		begin
			$display("ERROR at time %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("=== FAIL ===");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	task automatic place(input lc3b_isa_pkg::lc3b_word word);
		rom[6'(prog_len)] = word;
		prog_len++;
	endtask

	// ADD or AND, register form when imm_form is low
	task automatic alu_two_op
	(
		input logic is_and,
		input logic [2:0] dr,
		input logic [2:0] sr1,
		input logic imm_form,
		input int src
	);
		lc3b_isa_pkg::lc3b_word b;
		logic [4:0] low;
		if (imm_form)
		begin
			b = 16'(src);
			low = 5'(src);
		end
		else
		begin
			b = regs[3'(src)];
			low = {2'b00, 3'(src)};
		end
		place({is_and ? 4'b0101 : 4'b0001, dr, sr1, imm_form, low});
		regs[dr] = is_and ? (regs[sr1] & b) : (regs[sr1] + b);
	endtask

	task automatic invert_reg(input logic [2:0] dr, input logic [2:0] sr);
		place({4'b1001, dr, sr, 6'b111111});
		regs[dr] = ~regs[sr];
	endtask

	task automatic load_word(input logic [2:0] dr, input logic [2:0] base, input int off);
		lc3b_isa_pkg::lc3b_word addr;
		addr = regs[base] + 16'(2 * off);
		place({4'b0110, dr, base, 6'(off)});
		regs[dr] = ram[addr[8:1]];
	endtask

	// Stores in a branch shadow get no table entry
	task automatic store_word
	(
		input logic [2:0] sr,
		input logic [2:0] base,
		input int off,
		input logic reached
	);
		place({4'b0111, sr, base, 6'(off)});
		if (reached)
		begin
			exp_addr[4'(num_stores)] = regs[base] + 16'(2 * off);
			exp_data[4'(num_stores)] = regs[sr];
			num_stores++;
		end
	endtask

	task automatic load_address(input logic [2:0] dr, input int off);
		regs[dr] = 16'(2 * prog_len + 2 + 2 * off);
		place({4'b1110, dr, 9'(off)});
	endtask

	task automatic branch_on(input logic [2:0] nzp, input int off);
		place({4'b0000, nzp, 9'(off)});
	endtask

	task automatic build_program;
		alu_two_op(1'b0, 3'd1, 3'd0, 1'b1, 7);
		alu_two_op(1'b0, 3'd2, 3'd1, 1'b1, -3);
		alu_two_op(1'b0, 3'd3, 3'd1, 1'b0, 2);
		alu_two_op(1'b1, 3'd4, 3'd3, 1'b1, -6);
		alu_two_op(1'b1, 3'd5, 3'd4, 1'b0, 3);
		invert_reg(3'd6, 3'd5);
		store_word(3'd6, 3'd0, 5, 1'b1);
		store_word(3'd5, 3'd0, 4, 1'b1);
		store_word(3'd1, 3'd0, 0, 1'b1);
		store_word(3'd2, 3'd0, 1, 1'b1);
		store_word(3'd3, 3'd0, 2, 1'b1);
		store_word(3'd4, 3'd0, 3, 1'b1);
		// Load data straight into the next ADD
		load_word(3'd1, 3'd0, 10);
		alu_two_op(1'b0, 3'd2, 3'd1, 1'b1, 9);
		store_word(3'd2, 3'd0, 11, 1'b1);
		load_address(3'd3, 5);
		store_word(3'd3, 3'd0, 12, 1'b1);
		alu_two_op(1'b0, 3'd4, 3'd0, 1'b1, -1);
		branch_on(3'b100, 3);
		store_word(3'd4, 3'd0, 20, 1'b0);
		store_word(3'd4, 3'd0, 21, 1'b0);
		store_word(3'd4, 3'd0, 22, 1'b0);
		// Stale cc is still n here, only the bypass gives z
		alu_two_op(1'b0, 3'd5, 3'd0, 1'b1, 0);
		branch_on(3'b100, 1);
		store_word(3'd4, 3'd0, 13, 1'b1);
		halt_pc = 16'(2 * prog_len);
		branch_on(3'b111, -1);
	endtask

	// Both memories answer in the cycle the address appears
	always @(negedge clk)
	begin
		imem_rdata = rom[imem_addr[6:1]];
		dmem_rdata = dmem.read ? ram[dmem.addr[8:1]] : 16'h0000;
		// Store is in place before the next rising edge
		if (dmem.write)
			ram[dmem.addr[8:1]] = dmem.wdata;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("Halt loop not reached within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin
		prog_len = 0;
		num_stores = 0;
		void'($urandom(67));
		for (int i = 0; i < RAM_WORDS; i++)
			ram[8'(i)] = 16'($urandom);
		for (int i = 0; i < ROM_WORDS; i++)
			rom[6'(i)] = 16'h0000;
		for (int i = 0; i < 8; i++)
			regs[3'(i)] = 16'h0000;
		build_program();
		cycle_limit = 16 + 8 * prog_len + 50;

		repeat (16)
		begin
			@(negedge clk);
			check_value(imem_addr, 16'h0000, "fetch address in reset");
			check_value({14'b0, dmem.read, dmem.write}, 16'h0000, "data strobes in reset");
		end
		wait (arst_n);
		#10;
		check_value(imem_addr, 16'h0000, "fetch address after reset");
		check_value({14'b0, dmem.read, dmem.write}, 16'h0000, "data strobes after reset");

		for (int k = 0; k < num_stores; k++)
		begin
			do
				@(negedge clk);
			while (!dmem.write);
			check_value(dmem.addr, exp_addr[4'(k)], $sformatf("store %0d address", k));
			check_value(dmem.wdata, exp_data[4'(k)], $sformatf("store %0d data", k));
		end

		// Fetch returns to the closing BR once it is taken
		do
		begin
			@(negedge clk);
			if (dmem.write)
			begin
				$display("Store to %h after the last expected store", dmem.addr);
				$display("=== FAIL ===");
				$fatal(1, "Extra store");
			end
		end
		while (imem_addr != halt_pc);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== src.f ====
hw/lc3b_isa_pkg.sv
hw/lc3b_pipe_pkg.sv
hw/lc3b_fetch.sv
hw/lc3b_control_decode.sv
hw/lc3b_decode.sv
hw/lc3b_execute.sv
hw/lc3b_memory.sv
hw/lc3b_core.sv
tb/tb_clock_gen.sv
tb/lc3b_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--top-module lc3b_core_tb \
	-f src.f \
	--Mdir obj_dir \
	-o lc3b_core_tb

./obj_dir/lc3b_core_tb
